/* src/cpu_pkg.sv */
// Shared widths, opcodes, sequencer states, bus sources and control word for the accumulator CPU
package cpu_pkg;

    // Data and address widths
    typedef logic [7:0] data_t;             // One byte on the bus or in a register
    typedef logic [3:0] addr_t;             // RAM address, also the PC value

    localparam int RAM_DEPTH = 1 << $bits(addr_t);  // 16 bytes of program and data

    // Instruction opcodes, upper nibble of the instruction byte
    typedef enum logic [3:0] {
        OP_LDA = 4'd0,                      // acc <= ram[operand]
        OP_ADD = 4'd1,                      // acc <= acc + ram[operand]
        OP_SUB = 4'd2,                      // acc <= acc - ram[operand]
        OP_STA = 4'd3,                      // ram[operand] <= acc
        OP_LDI = 4'd4,                      // acc <= operand
        OP_JMP = 4'd5,                      // pc <= operand
        OP_JC  = 4'd6,                      // Jump if carry set
        OP_JZ  = 4'd7,                      // Jump if zero set
        OP_OUT = 4'd14,                     // out <= acc
        OP_HLT = 4'd15                      // Stop the sequencer
    } opcode_t;                             // Codes 8..13 are no-ops

    // Sequencer states, five clocks per instruction
    typedef enum logic [2:0] {
        S_FETCH_ADDR  = 3'd0,               // PC to MAR
        S_FETCH_INSTR = 3'd1,               // RAM to IR, PC + 1
        S_EXEC1       = 3'd2,
        S_EXEC2       = 3'd3,
        S_EXEC3       = 3'd4,
        S_HALT        = 3'd5                // Parked until reset or reload
    } seq_state_t;

    // Which block drives the internal bus
    typedef enum logic [2:0] {
        BUS_NONE       = 3'd0,              // Bus reads as zero
        BUS_PC         = 3'd1,
        BUS_RAM        = 3'd2,
        BUS_IR_OPERAND = 3'd3,              // Low nibble of IR
        BUS_ACC        = 3'd4,
        BUS_ALU        = 3'd5
    } bus_src_t;

    // Control word, all fields active high
    typedef struct packed {
        logic     pc_inc;                   // Count up
        logic     pc_load;                  // Jump, PC from bus
        logic     mar_load;                 // Address register from bus
        logic     ram_write;                // Bus into RAM at MAR
        logic     ir_load;
        logic     acc_load;
        logic     b_load;
        logic     out_load;
        logic     alu_sub;                  // Subtract instead of add
        logic     flags_load;               // Capture carry and zero
        bus_src_t bus_src;
    } ctrl_word_t;

    localparam ctrl_word_t CTRL_NONE = '0;  // Empty step, bus idle

endpackage

/* src/program_counter.sv */
// Program counter with hold to the start address, increment and jump load
`timescale 1ns/100ps

module program_counter
    import cpu_pkg::*;
#(
    parameter addr_t RESET_PC = '0          // Program start address
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       hold,                // Host is loading RAM
    input  ctrl_word_t ctrl,
    input  data_t      bus,
    output addr_t      pc
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (hold) begin
            pc <= RESET_PC;                 // Restart point once the load port lets go
        end else if (ctrl.pc_load) begin
            pc <= bus[$bits(addr_t)-1:0];   // Jump target from low nibble
        end else if (ctrl.pc_inc) begin
            pc <= pc + 1'b1;                // Wraps 15 -> 0
        end
    end

endmodule

/* src/control_sequencer.sv */
// Five-step instruction sequencer that decodes opcode and flags into the control word
`timescale 1ns/100ps

module control_sequencer
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       hold,                // Held in fetch while loading
    input  opcode_t    opcode,              // From the instruction register
    input  logic       carry,               // Registered ALU flags
    input  logic       zero,
    output ctrl_word_t ctrl,
    output logic       halted
);

    seq_state_t state, state_next;
    ctrl_word_t ctrl_dec;                   // Decoded word before the hold gate

    // State register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_FETCH_ADDR;
        end else if (hold) begin
            state <= S_FETCH_ADDR;          // Reload also leaves the halt state
        end else begin
            state <= state_next;
        end
    end

    // Fixed five-step walk with HLT parking after its last step
    always_comb begin
        case (state)
            S_FETCH_ADDR:  state_next = S_FETCH_INSTR;
            S_FETCH_INSTR: state_next = S_EXEC1;
            S_EXEC1:       state_next = S_EXEC2;
            S_EXEC2:       state_next = S_EXEC3;
            S_EXEC3:       state_next = (opcode == OP_HLT) ? S_HALT : S_FETCH_ADDR;
            S_HALT:        state_next = S_HALT;
            default:       state_next = S_FETCH_ADDR;
        endcase
    end

    // Moore-style control word per state
    always_comb begin
        ctrl_dec = CTRL_NONE;
        case (state)
            S_FETCH_ADDR: begin
                ctrl_dec.bus_src  = BUS_PC;
                ctrl_dec.mar_load = 1'b1;
            end
            S_FETCH_INSTR: begin
                ctrl_dec.bus_src = BUS_RAM;
                ctrl_dec.ir_load = 1'b1;
                ctrl_dec.pc_inc  = 1'b1;    // PC moves past the fetched byte
            end
            S_EXEC1: begin
                case (opcode)
                    OP_LDA, OP_ADD, OP_SUB, OP_STA: begin
                        ctrl_dec.bus_src  = BUS_IR_OPERAND;  // Operand is a RAM address
                        ctrl_dec.mar_load = 1'b1;
                    end
                    OP_LDI: begin
                        ctrl_dec.bus_src  = BUS_IR_OPERAND;
                        ctrl_dec.acc_load = 1'b1;
                    end
                    OP_JMP: begin
                        ctrl_dec.bus_src = BUS_IR_OPERAND;
                        ctrl_dec.pc_load = 1'b1;
                    end
                    OP_JC: begin
                        ctrl_dec.bus_src = BUS_IR_OPERAND;
                        ctrl_dec.pc_load = carry;   // Taken only when carry is set
                    end
                    OP_JZ: begin
                        ctrl_dec.bus_src = BUS_IR_OPERAND;
                        ctrl_dec.pc_load = zero;
                    end
                    OP_OUT: begin
                        ctrl_dec.bus_src  = BUS_ACC;
                        ctrl_dec.out_load = 1'b1;
                    end
                    default: ctrl_dec = CTRL_NONE;  // HLT and no-ops
                endcase
            end
            S_EXEC2: begin
                case (opcode)
                    OP_LDA: begin
                        ctrl_dec.bus_src  = BUS_RAM;
                        ctrl_dec.acc_load = 1'b1;
                    end
                    OP_ADD, OP_SUB: begin
                        ctrl_dec.bus_src = BUS_RAM;
                        ctrl_dec.b_load  = 1'b1;   // Second operand into B
                    end
                    OP_STA: begin
                        ctrl_dec.bus_src   = BUS_ACC;
                        ctrl_dec.ram_write = 1'b1;
                    end
                    default: ctrl_dec = CTRL_NONE;
                endcase
            end
            S_EXEC3: begin
                if (opcode == OP_ADD || opcode == OP_SUB) begin
                    ctrl_dec.bus_src    = BUS_ALU;
                    ctrl_dec.alu_sub    = (opcode == OP_SUB);
                    ctrl_dec.acc_load   = 1'b1;
                    ctrl_dec.flags_load = 1'b1;     // Only arithmetic touches flags
                end
            end
            default: ctrl_dec = CTRL_NONE;          // S_HALT issues nothing
        endcase
    end

    assign ctrl   = hold ? CTRL_NONE : ctrl_dec;    // Quiet while the host owns RAM
    assign halted = (state == S_HALT);

endmodule

/* src/alu.sv */
// Adder/subtractor with registered carry and zero flags
`timescale 1ns/100ps

module alu
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ctrl_word_t ctrl,
    input  data_t      acc,
    input  data_t      b,
    output data_t      result,
    output logic       carry,               // For SUB, set means no borrow
    output logic       zero
);

    data_t      b_op;                       // B or its complement
    logic [8:0] sum;                        // Carry out in the top bit

    // acc - b done as acc + ~b + 1
    always_comb begin
        b_op = ctrl.alu_sub ? ~b : b;
        sum  = {1'b0, acc} + {1'b0, b_op} + {8'h00, ctrl.alu_sub};
    end

    assign result = sum[7:0];

    // Flags hold between arithmetic instructions
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            carry <= 1'b0;
            zero  <= 1'b0;
        end else if (ctrl.flags_load) begin
            carry <= sum[8];
            zero  <= (sum[7:0] == 8'h00);
        end
    end

endmodule

/* src/datapath_regs.sv */
// Accumulator, B, instruction and output registers with the internal bus multiplexer
`timescale 1ns/100ps

module datapath_regs
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ctrl_word_t ctrl,
    input  addr_t      pc,
    input  data_t      ram_rdata,
    input  data_t      alu_result,
    output data_t      bus,
    output data_t      acc,
    output data_t      b,
    output opcode_t    opcode,
    output data_t      out_value,
    output logic       out_valid            // One cycle after an output load
);

    data_t ir;                              // Opcode high, operand low

    // Bus multiplexer with one driver per step
    always_comb begin
        case (ctrl.bus_src)
            BUS_PC:         bus = data_t'(pc);          // Zero extended
            BUS_RAM:        bus = ram_rdata;
            BUS_IR_OPERAND: bus = data_t'(ir[3:0]);
            BUS_ACC:        bus = acc;
            BUS_ALU:        bus = alu_result;
            default:        bus = '0;                   // BUS_NONE
        endcase
    end

    // Accumulator, instruction and output registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc       <= '0;
            ir        <= '0;
            out_value <= '0;
            out_valid <= 1'b0;
        end else begin
            if (ctrl.acc_load) acc <= bus;
            if (ctrl.ir_load)  ir  <= bus;
            if (ctrl.out_load) out_value <= bus;
            out_valid <= ctrl.out_load;     // Pulse lines up with the new value
        end
    end

    // Second ALU operand
    always_ff @(posedge clk) begin
        if (ctrl.b_load) begin
            b <= bus;
        end
    end

    assign opcode = opcode_t'(ir[7:4]);

endmodule

/* src/program_ram.sv */
// Memory address register and 16-byte program/data RAM with host load port
`timescale 1ns/100ps

module program_ram
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ctrl_word_t ctrl,
    input  data_t      bus,
    input  logic       load_en,             // Host owns writes while high
    input  logic       load_we,
    input  addr_t      load_addr,
    input  data_t      load_data,
    output data_t      rdata
);

    addr_t mar;                             // Memory address register
    data_t mem [RAM_DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mar <= '0;
        end else if (ctrl.mar_load) begin
            mar <= bus[$bits(addr_t)-1:0];  // Address from low nibble
        end
    end

    // Single write port shared by host and CPU
    always_ff @(posedge clk) begin
        if (load_en) begin
            if (load_we) begin
                mem[load_addr] <= load_data;
            end
        end else if (ctrl.ram_write) begin
            mem[mar] <= bus;                // STA
        end
    end

    assign rdata = mem[mar];                // Asynchronous read

endmodule

/* src/cpu_top.sv */
// Top level of the 8-bit accumulator CPU wiring sequencer, PC, ALU, registers and RAM
`timescale 1ns/100ps

module cpu_top
    import cpu_pkg::*;
#(
    parameter addr_t RESET_PC = '0          // First instruction address
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  load_en,                  // Hold CPU, host writes RAM
    input  logic  load_we,
    input  addr_t load_addr,
    input  data_t load_data,
    output data_t out_value,
    output logic  out_valid,
    output logic  halted
);

    ctrl_word_t ctrl;                       // Shared control word
    data_t      bus;
    data_t      acc;
    data_t      b;
    data_t      alu_result;
    data_t      ram_rdata;
    addr_t      pc;
    opcode_t    opcode;
    logic       carry;
    logic       zero;

    control_sequencer u_seq (
        .clk    (clk),
        .rst_n  (rst_n),
        .hold   (load_en),
        .opcode (opcode),
        .carry  (carry),
        .zero   (zero),
        .ctrl   (ctrl),
        .halted (halted)
    );

    program_counter #(
        .RESET_PC (RESET_PC)
    ) u_pc (
        .clk   (clk),
        .rst_n (rst_n),
        .hold  (load_en),
        .ctrl  (ctrl),
        .bus   (bus),
        .pc    (pc)
    );

    alu u_alu (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctrl   (ctrl),
        .acc    (acc),
        .b      (b),
        .result (alu_result),
        .carry  (carry),
        .zero   (zero)
    );

    datapath_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .pc         (pc),
        .ram_rdata  (ram_rdata),
        .alu_result (alu_result),
        .bus        (bus),
        .acc        (acc),
        .b          (b),
        .opcode     (opcode),
        .out_value  (out_value),
        .out_valid  (out_valid)
    );

    program_ram u_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .bus       (bus),
        .load_en   (load_en),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .rdata     (ram_rdata)
    );

endmodule

/* testbench/clock_gen.sv */
// Testbench clock source and power-on reset with a reset request input
`timescale 1ns/100ps

module clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 3
) (
    input  logic rst_req,                   // Extra reset from the test sequence
    output logic clk,
    output logic rst_n
);

    logic por_n;                            // Power-on part of the reset

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        por_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        por_n <= 1'b1;
    end

    assign rst_n = por_n & ~rst_req;

endmodule

/* testbench/cpu_properties.sv */
// Concurrent checks on the CPU control word and status outputs for binding to cpu_top
`timescale 1ns/100ps

module cpu_properties
    import cpu_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       load_en,
    input logic       out_valid,
    input logic       halted,
    input ctrl_word_t ctrl
);

    int violations = 0;                     // Count of failed assertions

    // Output pulse lasts one cycle
    assert property (@(posedge clk) disable iff (!rst_n) out_valid |=> !out_valid)
        else begin
            $error("out_valid high for two cycles in a row");
            violations++;
        end

    // Halt state issues nothing
    assert property (@(posedge clk) disable iff (!rst_n) halted |-> ctrl == CTRL_NONE)
        else begin
            $error("control word not empty while halted");
            violations++;
        end

    // CPU stays quiet while the host owns RAM
    assert property (@(posedge clk) disable iff (!rst_n) load_en |-> ctrl == CTRL_NONE)
        else begin
            $error("control word not empty while load_en is high");
            violations++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) !(ctrl.pc_load && ctrl.pc_inc))
        else begin
            $error("pc_load and pc_inc set together");
            violations++;
        end

endmodule

bind cpu_top cpu_properties u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_en   (load_en),
    .out_valid (out_valid),
    .halted    (halted),
    .ctrl      (ctrl)
);

/* testbench/cpu_tb.sv */
// Testbench top with program loader, instruction-level reference model, output checker and watchdog
`timescale 1ns/100ps

module cpu_tb
    import cpu_pkg::*;
;

    localparam int N_RUNS       = 27;                       // Programs run over all tests
    localparam int HALT_LIMIT   = 200 * 5 + 50;             // Cycles allowed per program
    localparam int QUIET_CYCLES = 20;                       // Watched after HLT
    localparam int WATCHDOG_NS  = N_RUNS * 200 * 5 * 10 + 50000;

    // Images, byte 0 leftmost
    localparam logic [127:0] ARITH_IMG  = {8'h0A, 8'h1B, 8'hE0, 8'h2C, 8'hE0, 8'h1D, 8'hE0, 8'hF0,
                                           8'h00, 8'h00, 8'hC8, 8'h5A, 8'h40, 8'h1E, 8'h00, 8'h00};
    localparam logic [127:0] MEM_IMG    = {8'h47, 8'h1E, 8'h3F, 8'h43, 8'h1F, 8'hE0, 8'h0F, 8'h2E,
                                           8'hE0, 8'hF0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h10, 8'h00};
    localparam logic [127:0] COUNT_IMG  = {8'h0E, 8'hE0, 8'h2F, 8'h76, 8'h51, 8'h00, 8'hE0, 8'hF0,
                                           8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h03, 8'h01};
    localparam logic [127:0] CARRY_IMG  = {8'h0D, 8'h1E, 8'h65, 8'hE0, 8'hF0, 8'h49, 8'hE0, 8'h1F,
                                           8'h64, 8'hE0, 8'hF0, 8'h00, 8'h00, 8'hF0, 8'h20, 8'h01};
    localparam logic [127:0] HALT_IMG   = {8'h45, 8'hE0, 8'hF0, 104'h0};
    localparam logic [127:0] RELOAD_IMG = {8'h4C, 8'h1F, 8'hE0, 8'hF0, 88'h0, 8'h33};

    logic  clk, rst_n, rst_req;
    logic  load_en, load_we;
    addr_t load_addr;
    data_t load_data;
    data_t out_value;
    logic  out_valid, halted;

    data_t       prog [RAM_DEPTH];          // Image being run
    data_t       exp_q [$];                 // Outputs the model predicts
    data_t       exp_val;
    bit          model_halts;
    int          test_errs, pass_count, fail_count;
    logic [31:0] lcg_state;
    logic [127:0] img;

    clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(3)) u_clk (
        .rst_req (rst_req),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    cpu_top #(.RESET_PC(4'd0)) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .out_value (out_value),
        .out_valid (out_valid),
        .halted    (halted)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Instruction-level model, fills exp_q and returns 1 if HLT is reached
    function automatic bit model_run();
        data_t      mem [RAM_DEPTH];
        addr_t      pc;
        data_t      acc;
        data_t      instr;
        logic [8:0] sum;
        bit         c, z;
        pc  = 4'd0;
        acc = 8'h00;
        c   = 1'b0;
        z   = 1'b0;
        exp_q.delete();
        for (int i = 0; i < RAM_DEPTH; i++) mem[i] = prog[i];
        for (int step = 0; step < 200; step++) begin
            instr = mem[pc];
            pc    = pc + 4'd1;              // 4-bit wrap
            case (instr[7:4])
                4'd0: acc = mem[instr[3:0]];
                4'd1: begin
                    sum = {1'b0, acc} + {1'b0, mem[instr[3:0]]};
                    c   = sum[8];
                    acc = sum[7:0];
                    z   = (acc == 8'h00);
                end
                4'd2: begin
                    c   = (acc >= mem[instr[3:0]]);   // Carry means no borrow
                    acc = acc - mem[instr[3:0]];
                    z   = (acc == 8'h00);
                end
                4'd3:  mem[instr[3:0]] = acc;
                4'd4:  acc = {4'h0, instr[3:0]};
                4'd5:  pc = instr[3:0];
                4'd6:  if (c) pc = instr[3:0];
                4'd7:  if (z) pc = instr[3:0];
                4'd14: exp_q.push_back(acc);
                4'd15: return 1'b1;
                default: ;                  // No-op codes
            endcase
        end
        return 1'b0;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        rst_req <= 1'b1;
        repeat (3) @(posedge clk);
        rst_req <= 1'b0;
    endtask

    // Host writes all 16 bytes, then releases the CPU
    task automatic load_program();
        @(posedge clk);
        load_en <= 1'b1;
        for (int i = 0; i < RAM_DEPTH; i++) begin
            load_we   <= 1'b1;
            load_addr <= addr_t'(i);
            load_data <= prog[i];
            @(posedge clk);
        end
        load_we <= 1'b0;
        load_en <= 1'b0;
    endtask

    task automatic start_program(input logic [127:0] image, input bit do_reset);
        for (int i = 0; i < RAM_DEPTH; i++) prog[i] = image[127 - 8 * i -: 8];
        model_halts = model_run();
        test_errs   = 0;
        if (do_reset) apply_reset();
        load_program();
    endtask

    // Wait for halt, watch the quiet period, then report the test
    task automatic finish_program(input string name);
        int cycles;
        bit dropped;
        cycles  = 0;
        dropped = 1'b0;
        while (!halted && cycles < HALT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!model_halts) begin
            $display("%s: reference model did not reach HLT", name);
            test_errs++;
        end
        if (!halted) begin
            $display("%s: CPU did not halt within %0d cycles", name, HALT_LIMIT);
            test_errs++;
        end else begin
            repeat (QUIET_CYCLES) begin
                @(negedge clk);
                if (!halted) dropped = 1'b1;
            end
            if (dropped) begin
                $display("%s: halted dropped without reset or reload", name);
                test_errs++;
            end
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected outputs never appeared", name, exp_q.size());
            test_errs++;
        end
        if (test_errs == 0) pass_count++;
        else fail_count++;
        $display("test %-14s %s (%0d errors)", name, (test_errs == 0) ? "passed" : "failed",
                 test_errs);
    endtask

    // Straight-line program, instructions in 0..9, data in 10..15
    task automatic random_image(output logic [127:0] image);
        logic [31:0] r;
        addr_t       opd;
        image = '0;
        for (int i = 0; i < 16; i++) begin
            lcg_state = lcg_next(lcg_state);
            r   = lcg_state;
            opd = 4'd10 + 4'(r[23:16] % 6);
            if (i >= 10) begin
                image[127 - 8 * i -: 8] = r[23:16];               // Data byte
            end else if (i == 9) begin
                image[127 - 8 * i -: 8] = {OP_HLT, 4'h0};
            end else if (i == 8) begin
                image[127 - 8 * i -: 8] = {OP_OUT, 4'h0};
            end else begin
                case (r[26:24])
                    3'd0, 3'd1: image[127 - 8 * i -: 8] = {OP_LDI, r[11:8]};
                    3'd2: image[127 - 8 * i -: 8] = {OP_LDA, opd};
                    3'd3: image[127 - 8 * i -: 8] = {OP_ADD, opd};
                    3'd4: image[127 - 8 * i -: 8] = {OP_SUB, opd};
                    3'd5: image[127 - 8 * i -: 8] = {OP_STA, opd};
                    3'd6: image[127 - 8 * i -: 8] = {OP_OUT, 4'h0};
                    default: image[127 - 8 * i -: 8] = {4'd8 + 4'(r[15:12] % 6), 4'h0};
                endcase
            end
        end
    endtask

    // Compare every output pulse against the model
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("unexpected out_valid pulse at %0t ns, out_value %02h", $time, out_value);
                test_errs++;
            end else begin
                exp_val = exp_q.pop_front();
                if (out_value !== exp_val) begin
                    $display("error at %0t ns: out_value expected %02h got %02h",
                             $time, exp_val, out_value);
                    test_errs++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests completed");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        rst_req    = 1'b0;
        load_en    = 1'b0;
        load_we    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        pass_count = 0;
        fail_count = 0;
        lcg_state  = 32'h4c7a;
        wait (rst_n === 1'b1);

        start_program(ARITH_IMG, 1'b1);
        finish_program("arithmetic");
        start_program(MEM_IMG, 1'b1);
        finish_program("memory");
        start_program(COUNT_IMG, 1'b1);
        finish_program("countdown");
        start_program(CARRY_IMG, 1'b1);
        finish_program("carry jump");

        // Halt then reload without reset
        start_program(HALT_IMG, 1'b1);
        finish_program("halt");
        start_program(RELOAD_IMG, 1'b0);
        finish_program("reload");

        // Reset after two of the four countdown outputs
        start_program(COUNT_IMG, 1'b1);
        for (int c = 0; exp_q.size() > 2 && c < HALT_LIMIT; c++) @(negedge clk);
        @(posedge clk);
        rst_req <= 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        if (out_value !== 8'h00) begin
            $display("error at %0t ns: out_value expected 00 got %02h", $time, out_value);
            test_errs++;
        end
        if (halted !== 1'b0) begin
            $display("error at %0t ns: halted expected 0 got %b", $time, halted);
            test_errs++;
        end
        model_halts = model_run();              // Full sequence again from address 0
        @(posedge clk);
        rst_req <= 1'b0;
        finish_program("reset mid-run");

        for (int k = 0; k < 20; k++) begin
            random_image(img);
            start_program(img, 1'b1);
            finish_program($sformatf("random %0d", k));
        end

        $display("tests passed %0d, failed %0d, assertion failures %0d",
                 pass_count, fail_count, dut0.u_props.violations);
        if (fail_count == 0 && dut0.u_props.violations == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
src/cpu_pkg.sv
src/program_counter.sv
src/control_sequencer.sv
src/alu.sv
src/datapath_regs.sv
src/program_ram.sv
src/cpu_top.sv
testbench/clock_gen.sv
testbench/cpu_properties.sv
testbench/cpu_tb.sv

/* Bender.yml */
package:
  name: acc_cpu

sources:
  - files:
      - src/cpu_pkg.sv
      - src/program_counter.sv
      - src/control_sequencer.sv
      - src/alu.sv
      - src/datapath_regs.sv
      - src/program_ram.sv
      - src/cpu_top.sv
  - target: simulation
    files:
      - testbench/clock_gen.sv
      - testbench/cpu_properties.sv
      - testbench/cpu_tb.sv
